// ==== hdl/fx3_bus_pkg.sv ====
`default_nettype none

package fx3_bus_pkg;

    // data pins wired between fpga and bridge
    localparam int FX3_DATA_BITS = 16;

    // one word on the slave fifo data bus
    typedef logic [FX3_DATA_BITS-1:0] fx3_word_t;

    // a1:a0 socket select
    typedef logic [1:0] fx3_addr_t;

    // host to fpga socket, used while streaming out
    localparam fx3_addr_t ADDR_READ_THREAD = 2'd3;

    // fpga to host socket, used while streaming in
    localparam fx3_addr_t ADDR_WRITE_THREAD = 2'd0;

    // parked address, no thread touched
    localparam fx3_addr_t ADDR_PARKED = 2'd2;

    // bridge samples slrd low, data on pins this many cycles later
    localparam int FX3_READ_LATENCY = 2;

endpackage

`default_nettype wire

// ==== hdl/loop_ctrl_pkg.sv ====
`default_nettype none

package loop_ctrl_pkg;

    // bus master modes
    typedef enum logic [1:0] {
        // waiting for read thread ready
        MODE_IDLE       = 2'd0,
        // pulling one block from the bridge
        MODE_STREAM_OUT = 2'd1,
        // fixed gap between read and write
        MODE_TURNAROUND = 2'd2,
        // pushing the block back to the bridge
        MODE_STREAM_IN  = 2'd3
    } loop_mode_t;

    // words per block, one bridge buffer
    localparam int BLOCK_WORDS = 512;

    // wide enough to hold BLOCK_WORDS itself
    typedef logic [9:0] block_count_t;

    // block fifo depth is 2**FIFO_ADDR_BITS
    localparam int FIFO_ADDR_BITS = 10;

    // cycles spent in turnaround
    localparam int TURNAROUND_CYCLES = 10;

    // read in flight: pin register, bridge latency, capture register
    localparam int RD_PIPE_DEPTH = 1 + fx3_bus_pkg::FX3_READ_LATENCY + 1;

endpackage

`default_nettype wire

// ==== hdl/fx3_bus_port.sv ====
`default_nettype none

module fx3_bus_port (
    input  wire                           usb_clk,
    input  wire                           reset_,
    input  wire                           flag_a_i,
    input  wire                           flag_b_i,
    input  wire                           flag_c_i,
    input  wire                           flag_d_i,
    input  wire fx3_bus_pkg::fx3_word_t   data_i,
    input  wire loop_ctrl_pkg::loop_mode_t mode_i,
    input  wire                           rd_n_i,
    input  wire                           oe_n_i,
    input  wire                           wr_n_i,
    input  wire fx3_bus_pkg::fx3_word_t   wr_data_i,
    output logic                          flag_a_q_o,
    output logic                          flag_b_q_o,
    output logic                          flag_c_q_o,
    output logic                          flag_d_q_o,
    output fx3_bus_pkg::fx3_word_t        rd_data_o,
    output logic                          slcs_n_o,
    output logic                          slrd_n_o,
    output logic                          sloe_n_o,
    output logic                          slwr_n_o,
    output fx3_bus_pkg::fx3_addr_t        fifo_addr_o,
    output fx3_bus_pkg::fx3_word_t        data_o,
    output logic                          data_oe_o
);
    import fx3_bus_pkg::*;
    import loop_ctrl_pkg::*;

    fx3_addr_t addr_next;

    // socket select follows the mode
    always_comb begin
        case (mode_i)
            MODE_STREAM_OUT: addr_next = ADDR_READ_THREAD;
            MODE_STREAM_IN:  addr_next = ADDR_WRITE_THREAD;
            default:         addr_next = ADDR_PARKED;
        endcase
    end

    // flags from bridge, one stage
    always_ff @(posedge usb_clk or negedge reset_) begin
        if (!reset_) begin
            flag_a_q_o <= 1'b0;
            flag_b_q_o <= 1'b0;
            flag_c_q_o <= 1'b0;
            flag_d_q_o <= 1'b0;
        end else begin
            flag_a_q_o <= flag_a_i;
            flag_b_q_o <= flag_b_i;
            flag_c_q_o <= flag_c_i;
            flag_d_q_o <= flag_d_i;
        end
    end

    // controls to bridge, all active low
    always_ff @(posedge usb_clk or negedge reset_) begin
        if (!reset_) begin
            slcs_n_o    <= 1'b1;
            slrd_n_o    <= 1'b1;
            sloe_n_o    <= 1'b1;
            slwr_n_o    <= 1'b1;
            fifo_addr_o <= ADDR_PARKED;
        end else begin
            // deselect only while idle
            slcs_n_o    <= (mode_i == MODE_IDLE);
            slrd_n_o    <= rd_n_i;
            sloe_n_o    <= oe_n_i;
            slwr_n_o    <= wr_n_i;
            fifo_addr_o <= addr_next;
        end
    end

    // data capture and launch
    always_ff @(posedge usb_clk) begin
        rd_data_o <= data_i;
        data_o    <= wr_data_i;
    end

    // drive the pads only in a write cycle
    assign data_oe_o = ~slwr_n_o;

endmodule

`default_nettype wire

// ==== hdl/loop_mode_fsm.sv ====
`default_nettype none

module loop_mode_fsm (
    input  wire                       usb_clk,
    input  wire                       reset_,
    input  wire                       flag_c_q_i,
    input  wire                       rd_done_i,
    input  wire                       wr_done_i,
    output loop_ctrl_pkg::loop_mode_t mode_o,
    output logic                      rd_en_o,
    output logic                      wr_en_o
);
    import loop_ctrl_pkg::*;

    loop_mode_t   mode_q;
    loop_mode_t   mode_next;
    block_count_t turn_cnt;
    logic         turn_done;

    // turnaround counter has run down
    assign turn_done = (turn_cnt == '0);

    // next mode
    always_comb begin
        mode_next = mode_q;
        case (mode_q)
            MODE_IDLE: begin
                // bridge has a block for us
                if (flag_c_q_i) begin
                    mode_next = MODE_STREAM_OUT;
                end
            end
            MODE_STREAM_OUT: begin
                if (rd_done_i) begin
                    mode_next = MODE_TURNAROUND;
                end
            end
            MODE_TURNAROUND: begin
                if (turn_done) begin
                    mode_next = MODE_STREAM_IN;
                end
            end
            MODE_STREAM_IN: begin
                // whole block written back
                if (wr_done_i) begin
                    mode_next = MODE_IDLE;
                end
            end
            default: begin
                mode_next = MODE_IDLE;
            end
        endcase
    end

    // mode register and turnaround down-counter
    always_ff @(posedge usb_clk or negedge reset_) begin
        if (!reset_) begin
            mode_q   <= MODE_IDLE;
            turn_cnt <= '0;
        end else begin
            mode_q <= mode_next;
            // load on entry, so turnaround lasts TURNAROUND_CYCLES
            if (mode_q == MODE_STREAM_OUT) begin
                turn_cnt <= block_count_t'(TURNAROUND_CYCLES - 1);
            end else if (mode_q == MODE_TURNAROUND && !turn_done) begin
                turn_cnt <= turn_cnt - 1'b1;
            end
        end
    end

    assign mode_o = mode_q;

    // one engine active per mode
    assign rd_en_o = (mode_q == MODE_STREAM_OUT);
    assign wr_en_o = (mode_q == MODE_STREAM_IN);

endmodule

`default_nettype wire

// ==== hdl/stream_out_reader.sv ====
`default_nettype none

module stream_out_reader (
    input  wire                         usb_clk,
    input  wire                         reset_,
    input  wire                         rd_en_i,
    input  wire                         flag_d_q_i,
    input  wire fx3_bus_pkg::fx3_word_t rd_data_i,
    output logic                        rd_n_o,
    output logic                        oe_n_o,
    output logic                        push_o,
    output fx3_bus_pkg::fx3_word_t      push_data_o,
    output logic                        rd_done_o
);
    import loop_ctrl_pkg::*;

    block_count_t             rd_cnt;
    logic [RD_PIPE_DEPTH-1:0] inflight;
    logic                     issued_all;
    logic                     issue;

    // stop issuing at one block
    assign issued_all = (rd_cnt == block_count_t'(BLOCK_WORDS));

    // one read per cycle while the thread has data
    assign issue = rd_en_i && flag_d_q_i && !issued_all;

    always_ff @(posedge usb_clk or negedge reset_) begin
        if (!reset_) begin
            rd_cnt   <= '0;
            inflight <= '0;
        end else begin
            // bit k set means a read issued k+1 cycles ago
            inflight <= {inflight[RD_PIPE_DEPTH-2:0], issue};
            if (!rd_en_i) begin
                rd_cnt <= '0;
            end else if (issue) begin
                rd_cnt <= rd_cnt + 1'b1;
            end
        end
    end

    // strobe is registered at the pins
    assign rd_n_o = ~issue;
    // bridge drives the bus all through stream-out
    assign oe_n_o = ~rd_en_i;

    // landed word sits in the capture register
    assign push_o      = inflight[RD_PIPE_DEPTH-1];
    assign push_data_o = rd_data_i;

    // all issued and nothing left in flight
    assign rd_done_o = rd_en_i && issued_all && (inflight == '0);

endmodule

`default_nettype wire

// ==== hdl/stream_in_writer.sv ====
`default_nettype none

module stream_in_writer (
    input  wire                         usb_clk,
    input  wire                         reset_,
    input  wire                         wr_en_i,
    input  wire                         flag_a_q_i,
    input  wire                         flag_b_q_i,
    input  wire fx3_bus_pkg::fx3_word_t pop_data_i,
    input  wire                         empty_i,
    output logic                        pop_o,
    output logic                        wr_n_o,
    output fx3_bus_pkg::fx3_word_t      wr_data_o,
    output logic                        wr_done_o
);
    import loop_ctrl_pkg::*;

    block_count_t wr_cnt;
    logic         wrote_all;
    logic         bridge_ready;

    // thread ready and not full
    assign bridge_ready = flag_a_q_i && flag_b_q_i;

    assign wrote_all = (wr_cnt == block_count_t'(BLOCK_WORDS));

    // pop only with room at the bridge and data in the fifo
    assign pop_o = wr_en_i && bridge_ready && !empty_i && !wrote_all;

    // words written this block
    always_ff @(posedge usb_clk or negedge reset_) begin
        if (!reset_) begin
            wr_cnt <= '0;
        end else if (!wr_en_i) begin
            wr_cnt <= '0;
        end else if (pop_o) begin
            wr_cnt <= wr_cnt + 1'b1;
        end
    end

    // head word and strobe leave together
    // both land in the same pin register stage
    assign wr_n_o    = ~pop_o;
    assign wr_data_o = pop_data_i;

    // held one cycle, mode leaves stream-in next edge
    assign wr_done_o = wr_en_i && wrote_all;

endmodule

`default_nettype wire

// ==== hdl/block_fifo.sv ====
`default_nettype none

module block_fifo (
    input  wire                         usb_clk,
    input  wire                         reset_,
    input  wire                         push_i,
    input  wire fx3_bus_pkg::fx3_word_t push_data_i,
    input  wire                         pop_i,
    output fx3_bus_pkg::fx3_word_t      pop_data_o,
    output logic                        empty_o,
    output logic                        full_o
);
    import fx3_bus_pkg::*;
    import loop_ctrl_pkg::*;

    fx3_word_t                 mem [2**FIFO_ADDR_BITS];
    logic [FIFO_ADDR_BITS-1:0] wr_ptr;
    logic [FIFO_ADDR_BITS-1:0] rd_ptr;
    // one extra bit to tell full from empty
    logic [FIFO_ADDR_BITS:0]   fill_cnt;
    logic                      do_push;
    logic                      do_pop;

    // ignore push when full, pop when empty
    assign do_push = push_i && !full_o;
    assign do_pop  = pop_i && !empty_o;

    // storage
    always_ff @(posedge usb_clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data_i;
        end
    end

    // pointers and fill level
    always_ff @(posedge usb_clk or negedge reset_) begin
        if (!reset_) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            fill_cnt <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   fill_cnt <= fill_cnt + 1'b1;
                2'b01:   fill_cnt <= fill_cnt - 1'b1;
                default: fill_cnt <= fill_cnt;
            endcase
        end
    end

    // head word always visible
    assign pop_data_o = mem[rd_ptr];

    assign empty_o = (fill_cnt == '0);
    // msb set only at 2**FIFO_ADDR_BITS
    assign full_o  = fill_cnt[FIFO_ADDR_BITS];

endmodule

`default_nettype wire

// ==== hdl/fx3_loop_top.sv ====
`default_nettype none

module fx3_loop_top (
    input  wire                         usb_clk,
    input  wire                         reset_,
    input  wire                         flag_a_i,
    input  wire                         flag_b_i,
    input  wire                         flag_c_i,
    input  wire                         flag_d_i,
    input  wire fx3_bus_pkg::fx3_word_t data_i,
    output logic                        slcs_n_o,
    output logic                        slrd_n_o,
    output logic                        sloe_n_o,
    output logic                        slwr_n_o,
    output fx3_bus_pkg::fx3_addr_t      fifo_addr_o,
    output fx3_bus_pkg::fx3_word_t      data_o,
    output logic                        data_oe_o
);
    import fx3_bus_pkg::*;
    import loop_ctrl_pkg::*;

    // registered flags
    logic       flag_a_q;
    logic       flag_b_q;
    logic       flag_c_q;
    logic       flag_d_q;

    // sequencing
    loop_mode_t mode;
    logic       rd_en;
    logic       wr_en;
    logic       rd_done;
    logic       wr_done;

    // read side
    logic       rd_n;
    logic       oe_n;
    fx3_word_t  rd_data;
    logic       push;
    fx3_word_t  push_data;

    // write side
    logic       pop;
    fx3_word_t  pop_data;
    logic       fifo_empty;
    logic       wr_n;
    fx3_word_t  wr_data;

    fx3_bus_port i_bus_port (
        .usb_clk     (usb_clk),
        .reset_      (reset_),
        .flag_a_i    (flag_a_i),
        .flag_b_i    (flag_b_i),
        .flag_c_i    (flag_c_i),
        .flag_d_i    (flag_d_i),
        .data_i      (data_i),
        .mode_i      (mode),
        .rd_n_i      (rd_n),
        .oe_n_i      (oe_n),
        .wr_n_i      (wr_n),
        .wr_data_i   (wr_data),
        .flag_a_q_o  (flag_a_q),
        .flag_b_q_o  (flag_b_q),
        .flag_c_q_o  (flag_c_q),
        .flag_d_q_o  (flag_d_q),
        .rd_data_o   (rd_data),
        .slcs_n_o    (slcs_n_o),
        .slrd_n_o    (slrd_n_o),
        .sloe_n_o    (sloe_n_o),
        .slwr_n_o    (slwr_n_o),
        .fifo_addr_o (fifo_addr_o),
        .data_o      (data_o),
        .data_oe_o   (data_oe_o)
    );

    loop_mode_fsm i_mode_fsm (
        .usb_clk    (usb_clk),
        .reset_     (reset_),
        .flag_c_q_i (flag_c_q),
        .rd_done_i  (rd_done),
        .wr_done_i  (wr_done),
        .mode_o     (mode),
        .rd_en_o    (rd_en),
        .wr_en_o    (wr_en)
    );

    stream_out_reader i_reader (
        .usb_clk     (usb_clk),
        .reset_      (reset_),
        .rd_en_i     (rd_en),
        .flag_d_q_i  (flag_d_q),
        .rd_data_i   (rd_data),
        .rd_n_o      (rd_n),
        .oe_n_o      (oe_n),
        .push_o      (push),
        .push_data_o (push_data),
        .rd_done_o   (rd_done)
    );

    // reader never exceeds one block, full is not needed
    block_fifo i_block_fifo (
        .usb_clk     (usb_clk),
        .reset_      (reset_),
        .push_i      (push),
        .push_data_i (push_data),
        .pop_i       (pop),
        .pop_data_o  (pop_data),
        .empty_o     (fifo_empty),
        .full_o      ()
    );

    stream_in_writer i_writer (
        .usb_clk    (usb_clk),
        .reset_     (reset_),
        .wr_en_i    (wr_en),
        .flag_a_q_i (flag_a_q),
        .flag_b_q_i (flag_b_q),
        .pop_data_i (pop_data),
        .empty_i    (fifo_empty),
        .pop_o      (pop),
        .wr_n_o     (wr_n),
        .wr_data_o  (wr_data),
        .wr_done_o  (wr_done)
    );

endmodule

`default_nettype wire

// ==== dv/fx3_loop_tb.sv ====
`default_nettype none

module fx3_loop_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import fx3_bus_pkg::*;
    import loop_ctrl_pkg::*;

    // blocks moved over the whole run: 1 + 1 + 1 + 2
    localparam int TEST_BLOCKS    = 5;
    localparam int TIMEOUT_CYCLES = TEST_BLOCKS * (2 * BLOCK_WORDS + 200);

    logic      usb_clk = 1'b0;
    logic      reset_;
    logic      flag_a_i;
    logic      flag_b_i;
    logic      flag_c_i;
    logic      flag_d_i;
    fx3_word_t data_in;
    logic      slcs_n;
    logic      slrd_n;
    logic      sloe_n;
    logic      slwr_n;
    fx3_addr_t fifo_addr;
    fx3_word_t data_out;
    logic      data_oe;

    // bridge model controls, written by the tests
    logic      bridge_live = 1'b0;
    logic      rd_stall_en = 1'b0;
    logic      wr_stall_en = 1'b0;
    int        blocks_wanted = 0;

    // bridge model status
    int        blocks_started = 0;
    int        blocks_done = 0;
    int        blk_reads = 0;
    int        last_reads = 0;

    // words the bridge hands out, words expected back, words seen written
    fx3_word_t src_q[$];
    fx3_word_t exp_q[$];
    fx3_word_t wr_q[$];

    string     cur_test = "reset";
    int        err_cnt = 0;
    int        err_at_start = 0;
    int        check_cnt = 0;
    int        test_cnt = 0;
    int        cycle_cnt = 0;
    int        seed = 32'h5800_4091;

    // 4 ns clock
    always #2 usb_clk = ~usb_clk;

    fx3_loop_top i_dut (
        .usb_clk     (usb_clk),
        .reset_      (reset_),
        .flag_a_i    (flag_a_i),
        .flag_b_i    (flag_b_i),
        .flag_c_i    (flag_c_i),
        .flag_d_i    (flag_d_i),
        .data_i      (data_in),
        .slcs_n_o    (slcs_n),
        .slrd_n_o    (slrd_n),
        .sloe_n_o    (sloe_n),
        .slwr_n_o    (slwr_n),
        .fifo_addr_o (fifo_addr),
        .data_o      (data_out),
        .data_oe_o   (data_oe)
    );

    task automatic check_word(input string what, input fx3_word_t exp, input fx3_word_t act);
        check_cnt++;
        if (act !== exp) begin
            err_cnt++;
            $display("Mismatch in %s, %s: expected %h actual %h", cur_test, what, exp, act);
        end
    endtask

    task automatic check_addr(input string what, input fx3_addr_t exp, input fx3_addr_t act);
        check_cnt++;
        if (act !== exp) begin
            err_cnt++;
            $display("Mismatch in %s, %s: expected %0d actual %0d", cur_test, what, exp, act);
        end
    endtask

    task automatic check_bit(input string what, input logic exp, input logic act);
        check_cnt++;
        if (act !== exp) begin
            err_cnt++;
            $display("Mismatch in %s, %s: expected %b actual %b", cur_test, what, exp, act);
        end
    endtask

    task automatic report_error(input string msg);
        err_cnt++;
        $display("Error in %s: %s", cur_test, msg);
    endtask

    // bridge model
    // outputs are read 1ns after the edge, where they hold what the bridge
    // samples at the next edge; inputs change at the same point
    initial begin : bridge_model
        logic [FX3_READ_LATENCY:0] rd_sr;
        logic [1:0]                rd_ok_hist;
        logic [1:0]                wr_ok_hist;
        logic                      cs_seen;
        logic                      drop_a;
        int                        rd_stall;
        int                        wr_stall;
        int                        r;
        rd_sr      = '0;
        rd_ok_hist = '0;
        wr_ok_hist = '0;
        cs_seen    = 1'b0;
        drop_a     = 1'b0;
        rd_stall   = 0;
        wr_stall   = 0;
        flag_a_i   = 1'b0;
        flag_b_i   = 1'b0;
        flag_c_i   = 1'b0;
        flag_d_i   = 1'b0;
        data_in    = '0;
        forever begin
            @(posedge usb_clk);
            #1;
            if (!slrd_n) begin
                blk_reads++;
                check_addr("address during read", ADDR_READ_THREAD, fifo_addr);
                check_bit("sloe_n during read", 1'b0, sloe_n);
                // issued from the flag as driven two cycles back
                if (!rd_ok_hist[1]) begin
                    report_error("read strobe although flag_d was low");
                end
            end
            if (!slwr_n) begin
                wr_q.push_back(data_out);
                check_addr("address during write", ADDR_WRITE_THREAD, fifo_addr);
                check_bit("data_oe during write", 1'b1, data_oe);
                if (!wr_ok_hist[1]) begin
                    report_error("write strobe although a write flag was low");
                end
                if (blk_reads != BLOCK_WORDS) begin
                    report_error("write before the whole block was read");
                end
            end else begin
                check_bit("data_oe without write", 1'b0, data_oe);
            end
            if (!slrd_n && !slwr_n) begin
                report_error("read and write strobes low together");
            end
            if ((!slrd_n || !slwr_n) && slcs_n) begin
                report_error("strobe low while chip select is high");
            end

            // block starts at chip select low, ends when it rises
            if (!slcs_n && !cs_seen) begin
                cs_seen = 1'b1;
                blocks_started++;
            end else if (slcs_n && cs_seen) begin
                cs_seen    = 1'b0;
                last_reads = blk_reads;
                blk_reads  = 0;
                blocks_done++;
            end

            // read data, FX3_READ_LATENCY cycles after the sampled strobe
            rd_sr = {rd_sr[FX3_READ_LATENCY-1:0], ~slrd_n};
            if (rd_sr[FX3_READ_LATENCY]) begin
                if (src_q.size() == 0) begin
                    report_error("read beyond the source data");
                end else begin
                    data_in = src_q.pop_front();
                end
            end

            // random stretches of low flags
            r = $random(seed);
            if (rd_stall == 0 && rd_stall_en && r[3:0] == 4'd0) begin
                rd_stall = 1 + int'(r[5:4]);
            end
            if (wr_stall == 0 && wr_stall_en && r[11:8] == 4'd0) begin
                wr_stall = 1 + int'(r[13:12]);
                drop_a   = r[14];
            end
            flag_c_i = bridge_live && (blocks_started < blocks_wanted);
            flag_d_i = bridge_live && (rd_stall == 0);
            flag_a_i = bridge_live && !(wr_stall > 0 && drop_a);
            flag_b_i = bridge_live && !(wr_stall > 0 && !drop_a);
            if (rd_stall > 0) begin
                rd_stall--;
            end
            if (wr_stall > 0) begin
                wr_stall--;
            end
            rd_ok_hist = {rd_ok_hist[0], flag_d_i};
            wr_ok_hist = {wr_ok_hist[0], flag_a_i && flag_b_i};
        end
    end

    // watchdog
    always @(posedge usb_clk) begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Error: timeout after %0d cycles in %s", cycle_cnt, cur_test);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    task automatic start_test(input string name);
        cur_test     = name;
        err_at_start = err_cnt;
        test_cnt++;
    endtask

    task automatic end_test();
        $display("test %s done, %0d errors", cur_test, err_cnt - err_at_start);
    endtask

    // one block of source words, also kept as expected data
    task automatic load_block();
        fx3_word_t w;
        for (int i = 0; i < BLOCK_WORDS; i++) begin
            w = fx3_word_t'($random(seed));
            src_q.push_back(w);
            exp_q.push_back(w);
        end
    endtask

    // ask the bridge for a block and wait for chip select to rise again
    task automatic run_block();
        int target;
        target = blocks_done + 1;
        blocks_wanted++;
        while (blocks_done < target) begin
            @(negedge usb_clk);
        end
    endtask

    task automatic compare_block();
        fx3_word_t exp;
        if (last_reads != BLOCK_WORDS) begin
            report_error($sformatf("%0d reads sampled instead of %0d", last_reads, BLOCK_WORDS));
        end
        if (wr_q.size() != BLOCK_WORDS) begin
            report_error($sformatf("%0d words written back instead of %0d",
                                   wr_q.size(), BLOCK_WORDS));
        end
        for (int i = 0; i < BLOCK_WORDS; i++) begin
            exp = exp_q.pop_front();
            if (wr_q.size() != 0) begin
                check_word($sformatf("word %0d", i), exp, wr_q.pop_front());
            end
        end
        wr_q.delete();
        // back to idle
        @(negedge usb_clk);
        check_bit("slcs_n after block", 1'b1, slcs_n);
        check_bit("data_oe after block", 1'b0, data_oe);
        check_addr("address after block", ADDR_PARKED, fifo_addr);
    endtask

    task automatic test_idle_after_reset();
        start_test("idle_after_reset");
        repeat (16) begin
            @(negedge usb_clk);
            check_bit("slcs_n", 1'b1, slcs_n);
            check_bit("slrd_n", 1'b1, slrd_n);
            check_bit("sloe_n", 1'b1, sloe_n);
            check_bit("slwr_n", 1'b1, slwr_n);
            check_bit("data_oe", 1'b0, data_oe);
            check_addr("fifo_addr", ADDR_PARKED, fifo_addr);
        end
        end_test();
    endtask

    task automatic test_single_block();
        start_test("single_block");
        bridge_live = 1'b1;
        load_block();
        run_block();
        compare_block();
        end_test();
    endtask

    task automatic test_read_backpressure();
        start_test("read_backpressure");
        load_block();
        rd_stall_en = 1'b1;
        run_block();
        rd_stall_en = 1'b0;
        compare_block();
        end_test();
    endtask

    task automatic test_write_backpressure();
        start_test("write_backpressure");
        load_block();
        wr_stall_en = 1'b1;
        run_block();
        wr_stall_en = 1'b0;
        compare_block();
        end_test();
    endtask

    // two blocks back to back, each must return its own words
    task automatic test_block_separation();
        start_test("block_separation");
        load_block();
        load_block();
        run_block();
        compare_block();
        run_block();
        compare_block();
        end_test();
    endtask

    initial begin
        reset_ = 1'b0;
        repeat (4) @(posedge usb_clk);
        #1;
        reset_ = 1'b1;
        test_idle_after_reset();
        test_single_block();
        test_read_backpressure();
        test_write_backpressure();
        test_block_separation();
        $display("%0d tests, %0d checks, %0d errors", test_cnt, check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
hdl/fx3_bus_pkg.sv
hdl/loop_ctrl_pkg.sv
hdl/fx3_bus_port.sv
hdl/loop_mode_fsm.sv
hdl/stream_out_reader.sv
hdl/stream_in_writer.sv
hdl/block_fifo.sv
hdl/fx3_loop_top.sv
dv/fx3_loop_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --timing --timescale 1ns/100ps
TOP       = fx3_loop_tb
RTL_TOP   = fx3_loop_top
FILELIST  = filelist.f
OBJ_DIR   = obj_dir
SIM_BIN   = $(OBJ_DIR)/V$(TOP)

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

sim: build
	@out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qx "TESTBENCH PASSED"

clean:
	rm -rf $(OBJ_DIR)
